// ==== logic/cmd_regfile.sv ====
// Command register bank keeping the last data per command address, plus PTT.
`timescale 1ns/10ps
`default_nettype none

module cmd_regfile (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire hpsdr_proto_pkg::ds_cmd_t cmd,
  input  wire                          cmd_valid,
  input  wire [5:0]                    cfg_addr,
  output logic [31:0]                  cfg_data,
  output logic                         ptt,
  output logic                         resp_req
);

  localparam int NREGS = 64;  // One per 6-bit address.

  logic [31:0] regs [NREGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
      ptt      <= 1'b0;
      resp_req <= 1'b0;
    end else begin
      resp_req <= cmd_valid && cmd.resprqst;
      if (cmd_valid) begin
        regs[cmd.addr] <= cmd.data;
        ptt            <= cmd.ptt;  // Every command carries PTT.
      end
    end
  end

  assign cfg_data = regs[cfg_addr];

endmodule

`default_nettype wire

// ==== logic/ds_top.sv ====
// Downstream top: parser, two sample packers, buffer arbiter and command registers.
`timescale 1ns/10ps
`default_nettype none
`include "hpsdr_config.svh"

module ds_top (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire [15:0]            eth_port,
  input  wire                   eth_broadcast,
  input  wire                   eth_valid,
  input  wire [7:0]             eth_data,
  input  wire                   eth_unreachable,
  input  wire [`HPSDR_BUF_AW:0] buf_rd_addr,
  input  wire [5:0]             cfg_addr,
  output logic                  eth_metis_discovery,
  output logic                  run,
  output logic                  wide_spectrum,
  output logic                  ptt,
  output logic                  resp_req,
  output logic [31:0]           buf_rd_data,
  output logic [31:0]           cfg_data,
  output logic [1:0]            overflow  // Bit 0 LR, bit 1 IQ.
);
  import hpsdr_proto_pkg::*;
  import hpsdr_buf_pkg::*;

  logic [7:0] sample_data;
  logic       lr_valid;
  logic       iq_valid;
  ds_cmd_t    cmd;
  logic       cmd_valid;
  buf_wr_t    lr_wr;
  buf_wr_t    iq_wr;
  logic       lr_req;
  logic       iq_req;
  logic       lr_ack;
  logic       iq_ack;

  ds_unpacker u_unpacker (
    .clk                 (clk),
    .arst_n              (arst_n),
    .eth_port            (eth_port),
    .eth_broadcast       (eth_broadcast),
    .eth_valid           (eth_valid),
    .eth_data            (eth_data),
    .eth_unreachable     (eth_unreachable),
    .eth_metis_discovery (eth_metis_discovery),
    .run                 (run),
    .wide_spectrum       (wide_spectrum),
    .sample_data         (sample_data),
    .lr_valid            (lr_valid),
    .iq_valid            (iq_valid),
    .cmd                 (cmd),
    .cmd_valid           (cmd_valid)
  );

  sample_packer u_lr_packer (
    .clk        (clk),
    .arst_n     (arst_n),
    .src        (SRC_LR),
    .byte_data  (sample_data),
    .byte_valid (lr_valid),
    .ack        (lr_ack),
    .wr         (lr_wr),
    .req        (lr_req),
    .overflow   (overflow[0])
  );

  sample_packer u_iq_packer (
    .clk        (clk),
    .arst_n     (arst_n),
    .src        (SRC_IQ),
    .byte_data  (sample_data),
    .byte_valid (iq_valid),
    .ack        (iq_ack),
    .wr         (iq_wr),
    .req        (iq_req),
    .overflow   (overflow[1])
  );

  sample_buf_arbiter u_arbiter (
    .clk     (clk),
    .arst_n  (arst_n),
    .lr_wr   (lr_wr),
    .iq_wr   (iq_wr),
    .lr_req  (lr_req),
    .iq_req  (iq_req),
    .lr_ack  (lr_ack),
    .iq_ack  (iq_ack),
    .rd_addr (buf_rd_addr),
    .rd_data (buf_rd_data)
  );

  cmd_regfile u_regfile (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cfg_addr  (cfg_addr),
    .cfg_data  (cfg_data),
    .ptt       (ptt),
    .resp_req  (resp_req)
  );

endmodule

`default_nettype wire

// ==== logic/ds_unpacker.sv ====
// Downstream protocol 1 parser: preamble, frame type, commands and sample strobes.
`timescale 1ns/10ps
`default_nettype none
`include "hpsdr_config.svh"

module ds_unpacker (
  input  wire                      clk,
  input  wire                      arst_n,
  input  wire [15:0]               eth_port,
  input  wire                      eth_broadcast,
  input  wire                      eth_valid,
  input  wire [7:0]                eth_data,
  input  wire                      eth_unreachable,
  output logic                     eth_metis_discovery,
  output logic                     run,
  output logic                     wide_spectrum,
  output logic [7:0]               sample_data,
  output logic                     lr_valid,
  output logic                     iq_valid,
  output hpsdr_proto_pkg::ds_cmd_t cmd,
  output logic                     cmd_valid
);
  import hpsdr_proto_pkg::*;

  localparam logic [7:0] EP_SAMPLES = 8'h02;  // Endpoint carrying TX samples.

  ds_state_e   state;
  ds_state_e   state_next;
  frame_type_e frame_type;
  logic [5:0]  pushcnt;
  logic [5:0]  pushcnt_next;
  logic        subframe;
  logic        subframe_next;
  logic        run_next;
  logic        wide_spectrum_next;
  ds_cmd_t     cmd_next;
  logic        cmd_valid_next;
  logic        port_ok;

  assign port_ok     = (eth_port == `HPSDR_PORT);
  assign frame_type  = frame_type_e'(eth_data);
  assign sample_data = eth_data;  // Samples pass straight through.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= START;
      run           <= 1'b0;
      wide_spectrum <= 1'b0;
      pushcnt       <= '0;
      subframe      <= 1'b0;
      cmd_valid     <= 1'b0;
    end else begin
      pushcnt   <= pushcnt_next;
      subframe  <= subframe_next;
      cmd_valid <= cmd_valid_next;
      if (eth_unreachable) begin
        state         <= START;
        run           <= 1'b0;
        wide_spectrum <= 1'b0;
      end else if (!eth_valid) begin
        state <= START;  // Gap in the stream ends the frame.
      end else begin
        state         <= state_next;
        run           <= run_next;
        wide_spectrum <= wide_spectrum_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    cmd <= cmd_next;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next state and strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_next          = START;
    run_next            = run;
    wide_spectrum_next  = wide_spectrum;
    pushcnt_next        = pushcnt;
    subframe_next       = subframe;
    cmd_next            = cmd;
    cmd_valid_next      = 1'b0;
    eth_metis_discovery = 1'b0;
    lr_valid            = 1'b0;
    iq_valid            = 1'b0;

    case (state)
      START: begin
        subframe_next = 1'b0;
        if (eth_data == `HPSDR_PRE0 && port_ok) state_next = PREAMBLE;
      end
      PREAMBLE: begin
        if (eth_data == `HPSDR_PRE1 && port_ok) state_next = DECODE;
      end
      DECODE: begin
        case (frame_type)
          FRAME_DATA:     state_next = ENDPOINT;
          FRAME_RUNSTOP:  state_next = RUNSTOP;
          FRAME_DISCOVER: state_next = eth_broadcast ? DISCOVERY : START;
          default:        state_next = START;
        endcase
      end
      RUNSTOP: begin
        run_next           = eth_data[0];
        wide_spectrum_next = eth_data[1];
      end
      DISCOVERY: begin
        eth_metis_discovery = eth_valid;
        state_next          = DISCOVERY;  // Held until the frame ends.
      end
      ENDPOINT: begin
        if (eth_data == EP_SAMPLES) state_next = SEQNO3;
      end
      SEQNO3:   state_next = SEQNO2;
      SEQNO2:   state_next = SEQNO1;
      SEQNO1:   state_next = SEQNO0;
      SEQNO0:   state_next = SYNC2;
      SYNC2: begin
        pushcnt_next = '0;
        if (eth_data == `HPSDR_SYNC) state_next = SYNC1;
      end
      SYNC1: begin
        pushcnt_next = '0;
        if (eth_data == `HPSDR_SYNC) state_next = SYNC0;
      end
      SYNC0: begin
        pushcnt_next = '0;
        if (eth_data == `HPSDR_SYNC) state_next = CMDCTRL;
      end
      CMDCTRL: begin
        cmd_next.resprqst = eth_data[7];
        cmd_next.addr     = eth_data[6:1];
        cmd_next.ptt      = eth_data[0];
        state_next        = CMDDATA3;
      end
      CMDDATA3: begin
        cmd_next.data[31:24] = eth_data;
        state_next           = CMDDATA2;
      end
      CMDDATA2: begin
        cmd_next.data[23:16] = eth_data;
        state_next           = CMDDATA1;
      end
      CMDDATA1: begin
        cmd_next.data[15:8] = eth_data;
        state_next          = CMDDATA0;
      end
      CMDDATA0: begin
        cmd_next.data[7:0] = eth_data;
        cmd_valid_next     = eth_valid && !eth_unreachable;
        state_next         = PUSHL1;
      end
      PUSHL1, PUSHL0, PUSHR1: begin
        lr_valid   = eth_valid;
        state_next = ds_state_e'(state + 5'd1);
      end
      PUSHR0: begin
        lr_valid     = eth_valid;
        pushcnt_next = pushcnt + 6'd1;
        state_next   = PUSHI1;
      end
      PUSHI1, PUSHI0, PUSHQ1: begin
        iq_valid   = eth_valid;
        state_next = ds_state_e'(state + 5'd1);
      end
      PUSHQ0: begin
        iq_valid = eth_valid;
        if (pushcnt != 6'(`HPSDR_GROUPS)) begin
          state_next = PUSHL1;
        end else if (!subframe) begin
          subframe_next = 1'b1;  // Second subframe follows.
          state_next    = SYNC2;
        end
      end
      default: state_next = START;
    endcase
  end

  a_one_stream: assert property (@(posedge clk) disable iff (!arst_n)
    !(lr_valid && iq_valid));

  a_cmd_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    cmd_valid |=> !cmd_valid);

endmodule

`default_nettype wire

// ==== logic/hpsdr_buf_pkg.sv ====
// Sample buffer types shared by the packers and the buffer arbiter.
`default_nettype none
`include "hpsdr_config.svh"

package hpsdr_buf_pkg;

  // Also the top address bit of the buffer region.
  typedef enum logic {
    SRC_LR = 1'b0,
    SRC_IQ = 1'b1
  } sample_src_e;

  typedef struct packed {
    sample_src_e              src;
    logic [`HPSDR_BUF_AW-1:0] addr;
    logic [31:0]              data;
  } buf_wr_t;

endpackage

`default_nettype wire

// ==== logic/hpsdr_config.svh ====
// HPSDR downstream constants for port matching, framing bytes and buffer sizing.
`ifndef HPSDR_CONFIG_SVH
`define HPSDR_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol 1 framing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define HPSDR_PORT   16'd1024  // Accepted UDP port.
`define HPSDR_PRE0   8'hEF     // First Metis preamble byte.
`define HPSDR_PRE1   8'hFE     // Second Metis preamble byte.
`define HPSDR_SYNC   8'h7F     // Subframe sync byte.
`define HPSDR_GROUPS 63        // Sample groups per subframe.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define HPSDR_BUF_AW 8         // Address bits per source region.

`endif

// ==== logic/hpsdr_proto_pkg.sv ====
// Protocol types for the downstream parser: states, frame opcodes and command word.
`default_nettype none

package hpsdr_proto_pkg;

  // Values follow the legacy parser encoding.
  typedef enum logic [4:0] {
    START     = 5'h00,
    PREAMBLE  = 5'h01,
    DECODE    = 5'h02,
    RUNSTOP   = 5'h03,
    DISCOVERY = 5'h04,
    ENDPOINT  = 5'h05,
    SEQNO3    = 5'h06,
    SEQNO2    = 5'h07,
    SEQNO1    = 5'h08,
    SEQNO0    = 5'h0a,
    SYNC2     = 5'h10,
    SYNC1     = 5'h11,
    SYNC0     = 5'h12,
    CMDCTRL   = 5'h13,
    CMDDATA3  = 5'h14,
    CMDDATA2  = 5'h15,
    CMDDATA1  = 5'h16,
    CMDDATA0  = 5'h17,
    PUSHL1    = 5'h18,
    PUSHL0    = 5'h19,
    PUSHR1    = 5'h1a,
    PUSHR0    = 5'h1b,
    PUSHI1    = 5'h1c,
    PUSHI0    = 5'h1d,
    PUSHQ1    = 5'h1e,
    PUSHQ0    = 5'h1f
  } ds_state_e;

  typedef enum logic [7:0] {
    FRAME_DATA     = 8'h01,
    FRAME_DISCOVER = 8'h02,
    FRAME_RUNSTOP  = 8'h04
  } frame_type_e;

  typedef struct packed {
    logic        resprqst;  // Host asks for a response.
    logic [5:0]  addr;
    logic        ptt;
    logic [31:0] data;
  } ds_cmd_t;

endpackage

`default_nettype wire

// ==== logic/sample_buf_arbiter.sv ====
// Round-robin arbiter for the two packers, owning the sample buffer and its read port.
`timescale 1ns/10ps
`default_nettype none
`include "hpsdr_config.svh"

module sample_buf_arbiter (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire hpsdr_buf_pkg::buf_wr_t lr_wr,
  input  wire hpsdr_buf_pkg::buf_wr_t iq_wr,
  input  wire                        lr_req,
  input  wire                        iq_req,
  output logic                       lr_ack,
  output logic                       iq_ack,
  input  wire [`HPSDR_BUF_AW:0]      rd_addr,
  output logic [31:0]                rd_data
);
  import hpsdr_buf_pkg::*;

  localparam int DEPTH = 2 ** (`HPSDR_BUF_AW + 1);  // Both source regions.

  logic [31:0] mem [DEPTH];
  logic        lr_elig;
  logic        iq_elig;
  logic        grant;
  logic        sel_valid;
  sample_src_e grant_src;
  sample_src_e sel_port;
  sample_src_e last_src;
  buf_wr_t     sel_wr;

  // A port waiting on its ack or already selected is not eligible.
  assign lr_elig = lr_req && !lr_ack && !(sel_valid && sel_port == SRC_LR);
  assign iq_elig = iq_req && !iq_ack && !(sel_valid && sel_port == SRC_IQ);
  assign grant   = lr_elig || iq_elig;

  always_comb begin
    if (lr_elig && iq_elig) begin
      grant_src = (last_src == SRC_LR) ? SRC_IQ : SRC_LR;
    end else if (iq_elig) begin
      grant_src = SRC_IQ;
    end else begin
      grant_src = SRC_LR;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sel_valid <= 1'b0;
      sel_port  <= SRC_LR;
      last_src  <= SRC_IQ;  // LR wins the first tie.
      lr_ack    <= 1'b0;
      iq_ack    <= 1'b0;
    end else begin
      sel_valid <= grant;
      if (grant) begin
        sel_port <= grant_src;
        last_src <= grant_src;
      end
      if (lr_ack && !lr_req) lr_ack <= 1'b0;
      else if (sel_valid && sel_port == SRC_LR) lr_ack <= 1'b1;
      if (iq_ack && !iq_req) iq_ack <= 1'b0;
      else if (sel_valid && sel_port == SRC_IQ) iq_ack <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (grant) sel_wr <= (grant_src == SRC_IQ) ? iq_wr : lr_wr;
    if (sel_valid) mem[{sel_wr.src, sel_wr.addr}] <= sel_wr.data;
    rd_data <= mem[rd_addr];
  end

  // Each write serves one pending request in its own region.
  a_one_write: assert property (@(posedge clk) disable iff (!arst_n)
    sel_valid |-> (sel_wr.src == sel_port) &&
                  ((sel_port == SRC_LR) ? (lr_req && !lr_ack) : (iq_req && !iq_ack)));

endmodule

`default_nettype wire

// ==== logic/sample_packer.sv ====
// Sample packer: builds 32-bit words from a byte stream and hands them to the buffer.
`timescale 1ns/10ps
`default_nettype none
`include "hpsdr_config.svh"

module sample_packer (
  input  wire                            clk,
  input  wire                            arst_n,
  input  wire hpsdr_buf_pkg::sample_src_e src,
  input  wire [7:0]                      byte_data,
  input  wire                            byte_valid,
  input  wire                            ack,
  output hpsdr_buf_pkg::buf_wr_t         wr,
  output logic                           req,
  output logic                           overflow
);

  logic [1:0]               byte_cnt;
  logic [23:0]              shift_q;
  logic [`HPSDR_BUF_AW-1:0] wr_ptr;
  logic                     word_done;
  logic                     busy;

  assign word_done = byte_valid && (byte_cnt == 2'd3);
  assign busy      = req || ack;  // Slot is free once ack has dropped.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_cnt <= '0;
      wr_ptr   <= '0;
      req      <= 1'b0;
      overflow <= 1'b0;
    end else begin
      if (byte_valid) byte_cnt <= byte_cnt + 2'd1;
      if (req && ack) req <= 1'b0;
      if (word_done) begin
        if (busy) begin
          overflow <= 1'b1;  // Word lost, pointer stays.
        end else begin
          req    <= 1'b1;
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_valid) shift_q <= {shift_q[15:0], byte_data};
    if (word_done && !busy) begin
      wr.src  <= src;
      wr.addr <= wr_ptr;
      wr.data <= {shift_q, byte_data};  // First byte lands in the top.
    end
  end

  a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(req) |-> $past(ack));

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+logic
+incdir+verification
logic/hpsdr_proto_pkg.sv
logic/hpsdr_buf_pkg.sv
logic/ds_unpacker.sv
logic/sample_packer.sv
logic/sample_buf_arbiter.sv
logic/cmd_regfile.sv
logic/ds_top.sv
verification/ds_tb.sv

// ==== verification/ds_tb_model.svh ====
// Downstream testbench frame builder and reference model of buffer, registers and status.
`ifndef DS_TB_MODEL_SVH
`define DS_TB_MODEL_SVH

localparam int K_NONE    = 0;
localparam int K_LR      = 1;
localparam int K_IQ      = 2;
localparam int K_CMD     = 3;  // Last data byte of a command.
localparam int K_RUN     = 4;
localparam int BUF_WORDS = 1 << `HPSDR_BUF_AW;

logic [7:0]               tx_byte [$];
int                       tx_kind [$];
ds_cmd_t                  tx_cmd [$];
logic [31:0]              buf_exp [2][BUF_WORDS];
bit                       buf_set [2][BUF_WORDS];
logic [`HPSDR_BUF_AW-1:0] ptr_exp [2];
logic [23:0]              shift_exp [2];
int                       cnt_exp [2];
logic [31:0]              reg_exp [64];
logic                     run_exp;
logic                     wide_exp;
logic                     ptt_exp;
int                       resp_exp;

task automatic model_reset();
  for (int s = 0; s < 2; s++) begin
    ptr_exp[s]   = '0;
    shift_exp[s] = '0;
    cnt_exp[s]   = 0;
    for (int a = 0; a < BUF_WORDS; a++) begin
      buf_set[s][a] = 1'b0;
    end
  end
  for (int a = 0; a < 64; a++) begin
    reg_exp[a] = '0;
  end
  run_exp  = 1'b0;
  wide_exp = 1'b0;
  ptt_exp  = 1'b0;
  resp_exp = 0;
endtask

task automatic push_byte(input logic [7:0] b, input int kind, input ds_cmd_t c);
  tx_byte.push_back(b);
  tx_kind.push_back(kind);
  tx_cmd.push_back(c);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame builders
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic build_data_frame();
  ds_cmd_t    c;
  logic [7:0] ctrl;
  push_byte(`HPSDR_PRE0, K_NONE, '0);
  push_byte(`HPSDR_PRE1, K_NONE, '0);
  push_byte(8'h01, K_NONE, '0);  // Data frame.
  push_byte(8'h02, K_NONE, '0);  // Endpoint 2.
  repeat (4) push_byte(8'($urandom), K_NONE, '0);
  for (int s = 0; s < 2; s++) begin
    repeat (3) push_byte(`HPSDR_SYNC, K_NONE, '0);
    ctrl       = 8'($urandom);
    c.resprqst = ctrl[7];
    c.addr     = ctrl[6:1];
    c.ptt      = ctrl[0];
    c.data     = $urandom;
    push_byte(ctrl, K_NONE, '0);
    push_byte(c.data[31:24], K_NONE, '0);
    push_byte(c.data[23:16], K_NONE, '0);
    push_byte(c.data[15:8], K_NONE, '0);
    push_byte(c.data[7:0], K_CMD, c);
    for (int g = 0; g < `HPSDR_GROUPS; g++) begin
      repeat (4) push_byte(8'($urandom), K_LR, '0);
      repeat (4) push_byte(8'($urandom), K_IQ, '0);
    end
  end
endtask

task automatic build_runstop_frame(input logic [7:0] b);
  push_byte(`HPSDR_PRE0, K_NONE, '0);
  push_byte(`HPSDR_PRE1, K_NONE, '0);
  push_byte(8'h04, K_NONE, '0);
  push_byte(b, K_RUN, '0);
endtask

// Pad bytes stay below 80h so they never look like a preamble.
task automatic build_discovery_frame(input int pad);
  push_byte(`HPSDR_PRE0, K_NONE, '0);
  push_byte(`HPSDR_PRE1, K_NONE, '0);
  push_byte(8'h02, K_NONE, '0);
  repeat (pad) push_byte(8'($urandom) & 8'h7F, K_NONE, '0);
endtask

task automatic build_bad_preamble_frame();
  push_byte(`HPSDR_PRE0, K_NONE, '0);
  repeat (200) push_byte(8'($urandom) & 8'h7F, K_NONE, '0);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic apply_byte(input logic [7:0] b, input int kind, input ds_cmd_t c);
  int s;
  s = (kind == K_IQ) ? 1 : 0;
  if (kind == K_LR || kind == K_IQ) begin
    if (cnt_exp[s] == 3) begin
      buf_exp[s][ptr_exp[s]] = {shift_exp[s], b};  // First byte is the top one.
      buf_set[s][ptr_exp[s]] = 1'b1;
      ptr_exp[s]             = ptr_exp[s] + 1'b1;
    end
    shift_exp[s] = {shift_exp[s][15:0], b};
    cnt_exp[s]   = (cnt_exp[s] + 1) % 4;
  end else if (kind == K_CMD) begin
    reg_exp[c.addr] = c.data;
    ptt_exp         = c.ptt;
    if (c.resprqst) resp_exp++;
  end else if (kind == K_RUN) begin
    run_exp  = b[0];
    wide_exp = b[1];
  end
endtask

`endif

// ==== verification/ds_tb.sv ====
// Downstream subsystem testbench with random frames checked against a reference model.
`timescale 1ns/10ps
`default_nettype none
`include "hpsdr_config.svh"

module ds_tb;
  import hpsdr_proto_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_FRAMES = 14;
  localparam int DISC_PAD   = 40;  // Bytes after the discovery opcode.
  localparam longint WATCHDOG_CYCLES = NUM_FRAMES * 1100 + 2000;

  logic                   clk;
  logic                   arst_n;
  logic [15:0]            eth_port;
  logic                   eth_broadcast;
  logic                   eth_valid;
  logic [7:0]             eth_data;
  logic                   eth_unreachable;
  logic [`HPSDR_BUF_AW:0] buf_rd_addr;
  logic [5:0]             cfg_addr;
  logic                   eth_metis_discovery;
  logic                   run;
  logic                   wide_spectrum;
  logic                   ptt;
  logic                   resp_req;
  logic [31:0]            buf_rd_data;
  logic [31:0]            cfg_data;
  logic [1:0]             overflow;
  int                     errors;
  int                     resp_seen;
  int                     disc_seen;
  int unsigned            seed_ret;

  `include "ds_tb_model.svh"

  ds_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Sampled away from the driving edge.
  always @(negedge clk) begin
    if (arst_n && resp_req) resp_seen++;
    if (arst_n && eth_metis_discovery) disc_seen++;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Error: watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Driver and check tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic idle(input int n);
    eth_valid = 1'b0;
    eth_data  = 8'h00;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // A negative cut sends the whole frame.
  task automatic send_frame(input int cut, input bit apply);
    int n;
    n = (cut < 0 || cut > tx_byte.size()) ? tx_byte.size() : cut;
    for (int i = 0; i < n; i++) begin
      eth_valid = 1'b1;
      eth_data  = tx_byte[i];
      if (apply) apply_byte(tx_byte[i], tx_kind[i], tx_cmd[i]);
      @(posedge clk);
      #1;
    end
    tx_byte.delete();
    tx_kind.delete();
    tx_cmd.delete();
  endtask

  task automatic check_buffer();
    for (int s = 0; s < 2; s++) begin
      for (int a = 0; a < BUF_WORDS; a++) begin
        if (buf_set[s][a]) begin
          buf_rd_addr = (`HPSDR_BUF_AW + 1)'(s * BUF_WORDS + a);
          @(posedge clk);
          #1;
          check_value($sformatf("buf_rd_data[%0d]", buf_rd_addr), buf_rd_data,
                      buf_exp[s][a]);
        end
      end
    end
  endtask

  task automatic check_regs();
    for (int a = 0; a < 64; a++) begin
      cfg_addr = 6'(a);
      @(posedge clk);
      #1;
      check_value($sformatf("cfg_data[%0d]", a), cfg_data, reg_exp[a]);
    end
  endtask

  task automatic check_status();
    check_value("run", 32'(run), 32'(run_exp));
    check_value("wide_spectrum", 32'(wide_spectrum), 32'(wide_exp));
    check_value("ptt", 32'(ptt), 32'(ptt_exp));
    check_value("overflow", 32'(overflow), 32'd0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    seed_ret        = $urandom(95);
    arst_n          = 1'b0;
    eth_port        = `HPSDR_PORT;
    eth_broadcast   = 1'b0;
    eth_valid       = 1'b0;
    eth_data        = 8'h00;
    eth_unreachable = 1'b0;
    buf_rd_addr     = '0;
    cfg_addr        = '0;
    errors          = 0;
    resp_seen       = 0;
    disc_seen       = 0;
    model_reset();
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    idle(2);

    build_data_frame();  // Two frames, no gap between them.
    build_data_frame();
    send_frame(-1, 1'b1);
    idle(16);
    check_buffer();
    check_regs();
    check_status();

    repeat (4) begin
      build_runstop_frame(8'($urandom));
      send_frame(-1, 1'b1);
      idle(2);
      check_status();
    end
    build_runstop_frame(8'h03);
    send_frame(-1, 1'b1);
    idle(2);
    check_status();
    eth_unreachable = 1'b1;
    idle(1);
    eth_unreachable = 1'b0;
    run_exp         = 1'b0;
    wide_exp        = 1'b0;
    idle(1);
    check_status();

    eth_broadcast = 1'b1;
    disc_seen     = 0;
    build_discovery_frame(DISC_PAD);
    send_frame(-1, 1'b1);
    idle(2);
    check_value("eth_metis_discovery cycles", 32'(disc_seen), 32'(DISC_PAD));
    eth_broadcast = 1'b0;
    disc_seen     = 0;
    build_discovery_frame(DISC_PAD);
    send_frame(-1, 1'b1);
    idle(2);
    check_value("eth_metis_discovery cycles", 32'(disc_seen), 32'd0);

    eth_port = `HPSDR_PORT + 16'd1;
    build_data_frame();
    send_frame(-1, 1'b0);
    idle(4);
    eth_port = `HPSDR_PORT;
    build_bad_preamble_frame();
    send_frame(-1, 1'b1);
    idle(4);
    build_data_frame();
    send_frame(14, 1'b1);  // Ends inside the first command.
    idle(4);
    build_data_frame();
    send_frame(int'($urandom_range(900, 20)), 1'b1);
    idle(4);
    build_data_frame();
    send_frame(-1, 1'b1);
    idle(16);
    check_buffer();
    check_regs();
    check_status();
    check_value("resp_req pulses", 32'(resp_seen), 32'(resp_exp));

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
